//--- common/vision_pkg.sv
package vision_pkg;

  // rgb565 pixel as held in the frame store
  typedef struct packed {
    logic [4:0] r;
    logic [5:0] g;
    logic [4:0] b;
  } pixel_t;

  // 4-bit intensity, also used for threshold bounds
  typedef logic [3:0] chan_t;

  // one output color toward the dac
  typedef struct packed {
    chan_t r;
    chan_t g;
    chan_t b;
  } rgb444_t;

  // screen position
  typedef logic [10:0] hcoord_t;
  typedef logic [9:0] vcoord_t;

  // which channel feeds threshold and gray view
  typedef enum logic [1:0] {CHAN_RED, CHAN_GREEN, CHAN_BLUE, CHAN_LUMA} chan_sel_t;

  // what gets drawn on screen
  typedef enum logic [1:0] {VIEW_RAW, VIEW_GRAY, VIEW_MASK, VIEW_CROSS} view_t;

  // timing signals riding along the pixel stages
  typedef struct packed {
    logic hsync;
    logic vsync;
    logic blank;
  } sync_bundle_t;

  typedef struct packed {
    hcoord_t h;
    vcoord_t v;
  } coord_t;

  // luma weights on 8-bit channels, sum >> 8
  localparam logic [7:0] LUMA_R_COEF = 8'd66;
  localparam logic [7:0] LUMA_G_COEF = 8'd129;
  localparam logic [7:0] LUMA_B_COEF = 8'd25;

  localparam rgb444_t CROSS_COLOR = '{r: 4'h0, g: 4'hF, b: 4'h0};

  // counters to vga pins
  localparam int PIXEL_LATENCY = 6;

endpackage

//--- logic/vga_timing.sv
module vga_timing import vision_pkg::*; #(
  parameter int H_ACTIVE = 1024,
  parameter int H_FRONT  = 24,
  parameter int H_SYNC   = 136,
  parameter int H_BACK   = 160,
  parameter int V_ACTIVE = 768,
  parameter int V_FRONT  = 3,
  parameter int V_SYNC   = 6,
  parameter int V_BACK   = 29
) (
  input  logic    clk_65mhz,
  input  logic    sys_rst,
  output hcoord_t hcount,
  output vcoord_t vcount,
  output logic    hsync,
  output logic    vsync,
  output logic    blank
);

  localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

  // sync window sits between the porches
  localparam hcoord_t H_LAST       = hcoord_t'(H_TOTAL - 1);
  localparam hcoord_t H_SYNC_START = hcoord_t'(H_ACTIVE + H_FRONT);
  localparam hcoord_t H_SYNC_END   = hcoord_t'(H_ACTIVE + H_FRONT + H_SYNC);
  localparam vcoord_t V_LAST       = vcoord_t'(V_TOTAL - 1);
  localparam vcoord_t V_SYNC_START = vcoord_t'(V_ACTIVE + V_FRONT);
  localparam vcoord_t V_SYNC_END   = vcoord_t'(V_ACTIVE + V_FRONT + V_SYNC);

  hcoord_t h_next;
  vcoord_t v_next;

  // next position, row advances at end of line
  always_comb begin
    h_next = hcount + 1'b1;
    v_next = vcount;
    if (hcount == H_LAST) begin
      h_next = '0;
      v_next = (vcount == V_LAST) ? '0 : vcount + 1'b1;
    end
  end

  // flags decoded from next count so they line up with the counters
  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      hcount <= '0;
      vcount <= '0;
      hsync  <= 1'b0;
      vsync  <= 1'b0;
      blank  <= 1'b0;
    end else begin
      hcount <= h_next;
      vcount <= v_next;
      hsync  <= (h_next >= H_SYNC_START) && (h_next < H_SYNC_END);
      vsync  <= (v_next >= V_SYNC_START) && (v_next < V_SYNC_END);
      blank  <= (h_next >= hcoord_t'(H_ACTIVE)) || (v_next >= vcoord_t'(V_ACTIVE));
    end
  end

endmodule

//--- logic/timing_delay.sv
module timing_delay #(
  parameter int DEPTH = 1,
  parameter type payload_t = logic
) (
  input  logic     clk_65mhz,
  input  logic     sys_rst,
  input  payload_t din,
  output payload_t dout
);

  // one register per cycle of delay
  payload_t stage [DEPTH];

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        stage[i] <= '0;
      end
    end else begin
      stage[0] <= din;
      for (int i = 1; i < DEPTH; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  // oldest entry out
  assign dout = stage[DEPTH-1];

endmodule

//--- frame_store/frame_store.sv
module frame_store import vision_pkg::*; #(
  parameter int IMG_W = 320,
  parameter int IMG_H = 240
) (
  input  logic                           clk_65mhz,
  input  logic                           sys_rst,
  input  logic                           wr_en,
  input  logic [$clog2(IMG_W*IMG_H)-1:0] wr_addr,
  input  pixel_t                         wr_data,
  input  hcoord_t                        hcount,
  input  vcoord_t                        vcount,
  output pixel_t                         pixel,
  output logic                           in_image
);

  localparam int DEPTH  = IMG_W * IMG_H;
  localparam int ADDR_W = $clog2(DEPTH);

  pixel_t            mem [DEPTH];
  pixel_t            mem_q;
  logic [ADDR_W-1:0] rd_addr;
  logic              in_img_now;
  logic              in_img_a;
  logic              in_img_m;

  assign in_img_now = (hcount < hcoord_t'(IMG_W)) && (vcount < vcoord_t'(IMG_H));

  // stage 1: mirrored row-major address
  // column flips left to right, off-image reads park on 0
  always_ff @(posedge clk_65mhz) begin
    if (in_img_now) begin
      rd_addr <= ADDR_W'(int'(vcount) * IMG_W + (IMG_W - 1) - int'(hcount));
    end else begin
      rd_addr <= '0;
    end
  end

  // two-port ram, write side from outside, read side from the scan
  // stage 2 is the array read, stage 3 the output register
  always_ff @(posedge clk_65mhz) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
    mem_q <= mem[rd_addr];
    pixel <= in_img_m ? mem_q : '0;
  end

  // image flag follows the read through all three stages
  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      in_img_a <= 1'b0;
      in_img_m <= 1'b0;
      in_image <= 1'b0;
    end else begin
      in_img_a <= in_img_now;
      in_img_m <= in_img_a;
      in_image <= in_img_m;
    end
  end

endmodule

//--- logic/luma_convert.sv
module luma_convert import vision_pkg::*; (
  input  logic   clk_65mhz,
  input  logic   sys_rst,
  input  pixel_t pixel_in,
  input  logic   in_image_in,
  output chan_t  luma,
  output pixel_t pixel_out,
  output logic   in_image_out
);

  logic [7:0]  r8;
  logic [7:0]  g8;
  logic [7:0]  b8;
  logic [15:0] prod_r;
  logic [15:0] prod_g;
  logic [15:0] prod_b;
  logic [15:0] luma_sum;
  logic [7:0]  luma8;
  pixel_t      pixel_s1;
  logic        in_image_s1;

  // widen to 8 bits by repeating the top bits
  assign r8 = {pixel_in.r, pixel_in.r[4:2]};
  assign g8 = {pixel_in.g, pixel_in.g[5:4]};
  assign b8 = {pixel_in.b, pixel_in.b[4:2]};

  // weighted sum fits 16 bits, max is 255 * 220
  assign luma_sum = prod_r + prod_g + prod_b;
  assign luma8    = luma_sum[15:8];

  // stage 1 products, stage 2 sum and top nibble
  always_ff @(posedge clk_65mhz) begin
    prod_r    <= r8 * LUMA_R_COEF;
    prod_g    <= g8 * LUMA_G_COEF;
    prod_b    <= b8 * LUMA_B_COEF;
    pixel_s1  <= pixel_in;
    luma      <= luma8[7:4];
    pixel_out <= pixel_s1;
  end

  // flag keeps pace with the pixel
  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      in_image_s1  <= 1'b0;
      in_image_out <= 1'b0;
    end else begin
      in_image_s1  <= in_image_in;
      in_image_out <= in_image_s1;
    end
  end

endmodule

//--- logic/threshold_view.sv
module threshold_view import vision_pkg::*; (
  input  logic      clk_65mhz,
  input  logic      sys_rst,
  input  pixel_t    pixel,
  input  chan_t     luma,
  input  logic      in_image,
  input  coord_t    coord_in,
  input  logic      blank,
  input  chan_sel_t chan_sel,
  input  chan_t     lower,
  input  chan_t     upper,
  input  view_t     view,
  input  hcoord_t   com_x,
  input  vcoord_t   com_y,
  output chan_t     vga_r,
  output chan_t     vga_g,
  output chan_t     vga_b,
  output logic      mask,
  output coord_t    coord_out
);

  rgb444_t raw;
  rgb444_t color;
  rgb444_t color_q;
  chan_t   chan;
  logic    in_band;
  logic    on_cross;

  // rgb444 from the top bits of each field
  assign raw = '{r: pixel.r[4:1], g: pixel.g[5:2], b: pixel.b[4:1]};

  always_comb begin
    case (chan_sel)
      CHAN_RED:   chan = raw.r;
      CHAN_GREEN: chan = raw.g;
      CHAN_BLUE:  chan = raw.b;
      default:    chan = luma;
    endcase
  end

  // inclusive bounds, nothing outside the image
  assign in_band  = in_image && (chan >= lower) && (chan <= upper);
  // last centroid's row and column
  assign on_cross = (coord_in.h == com_x) || (coord_in.v == com_y);

  always_comb begin
    case (view)
      VIEW_GRAY:  color = '{r: chan, g: chan, b: chan};
      VIEW_MASK:  color = in_band ? '{r: 4'hF, g: 4'hF, b: 4'hF} : '0;
      VIEW_CROSS: color = on_cross ? CROSS_COLOR : raw;
      default:    color = raw;
    endcase
  end

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      color_q <= '0;
      mask    <= 1'b0;
    end else begin
      color_q <= color;
      mask    <= in_band;
    end
  end

  // coordinates stay paired with their mask bit
  always_ff @(posedge clk_65mhz) begin
    coord_out <= coord_in;
  end

  // blank arrives already delayed to the output cycle
  assign vga_r = blank ? '0 : color_q.r;
  assign vga_g = blank ? '0 : color_q.g;
  assign vga_b = blank ? '0 : color_q.b;

endmodule

//--- logic/centroid.sv
module centroid import vision_pkg::*; (
  input  logic    clk_65mhz,
  input  logic    sys_rst,
  input  logic    mask,
  input  coord_t  coord,
  output hcoord_t com_x,
  output vcoord_t com_y,
  output logic    com_valid
);

  localparam int HW    = $bits(hcoord_t);
  localparam int VW    = $bits(vcoord_t);
  localparam int CNT_W = HW + VW + 1;
  localparam int SUM_W = 32;
  localparam int REM_W = CNT_W + 1;

  typedef enum logic [1:0] {DIV_IDLE, DIV_X, DIV_Y} div_state_t;

  div_state_t        state;
  logic              at_origin;
  logic              at_origin_q;
  logic              frame_start;
  logic [SUM_W-1:0]  sum_x;
  logic [SUM_W-1:0]  sum_y;
  logic [SUM_W-1:0]  sum_y_hold;
  logic [CNT_W-1:0]  cnt;
  logic [CNT_W-1:0]  den;
  logic [REM_W-1:0]  rem;
  logic [REM_W-1:0]  trial;
  logic [HW-1:0]     dvd;
  logic [HW-1:0]     quo;
  logic [HW-1:0]     quo_next;
  logic [3:0]        bit_cnt;
  logic              fits;
  hcoord_t           qx;

  // first (0,0) of a run, repeats after reset count once
  assign at_origin   = (coord.h == '0) && (coord.v == '0);
  assign frame_start = at_origin && !at_origin_q;

  // restoring step, one quotient bit
  assign trial    = {rem[REM_W-2:0], dvd[HW-1]};
  assign fits     = trial >= REM_W'(den);
  assign quo_next = {quo[HW-2:0], fits};

  // per-frame sums, restart includes the origin pixel itself
  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      at_origin_q <= 1'b0;
      sum_x       <= '0;
      sum_y       <= '0;
      cnt         <= '0;
    end else begin
      at_origin_q <= at_origin;
      if (frame_start) begin
        sum_x <= mask ? SUM_W'(coord.h) : '0;
        sum_y <= mask ? SUM_W'(coord.v) : '0;
        cnt   <= CNT_W'(mask);
      end else if (mask) begin
        sum_x <= sum_x + SUM_W'(coord.h);
        sum_y <= sum_y + SUM_W'(coord.v);
        cnt   <= cnt + 1'b1;
      end
    end
  end

  // shared divider, x first then y
  // quotient fits the coordinate width so the upper dividend bits preload rem
  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      state     <= DIV_IDLE;
      bit_cnt   <= '0;
      com_x     <= '0;
      com_y     <= '0;
      com_valid <= 1'b0;
    end else begin
      com_valid <= 1'b0;
      if (frame_start) begin
        if (cnt == '0) begin
          // empty mask
          com_x     <= '0;
          com_y     <= '0;
          com_valid <= 1'b1;
          state     <= DIV_IDLE;
        end else begin
          den        <= cnt;
          sum_y_hold <= sum_y;
          rem        <= REM_W'(sum_x >> HW);
          dvd        <= sum_x[HW-1:0];
          quo        <= '0;
          bit_cnt    <= 4'(HW);
          state      <= DIV_X;
        end
      end else if (state != DIV_IDLE) begin
        rem     <= fits ? trial - REM_W'(den) : trial;
        quo     <= quo_next;
        dvd     <= {dvd[HW-2:0], 1'b0};
        bit_cnt <= bit_cnt - 1'b1;
        if (bit_cnt == 4'd1) begin
          if (state == DIV_X) begin
            qx      <= quo_next;
            rem     <= REM_W'(sum_y_hold >> VW);
            dvd     <= {sum_y_hold[VW-1:0], {(HW - VW){1'b0}}};
            quo     <= '0;
            bit_cnt <= 4'(VW);
            state   <= DIV_Y;
          end else begin
            com_x     <= qx;
            com_y     <= quo_next[VW-1:0];
            com_valid <= 1'b1;
            state     <= DIV_IDLE;
          end
        end
      end
    end
  end

endmodule

//--- logic/video_top.sv
module video_top import vision_pkg::*; #(
  parameter int H_ACTIVE = 1024,
  parameter int H_FRONT  = 24,
  parameter int H_SYNC   = 136,
  parameter int H_BACK   = 160,
  parameter int V_ACTIVE = 768,
  parameter int V_FRONT  = 3,
  parameter int V_SYNC   = 6,
  parameter int V_BACK   = 29,
  parameter int IMG_W    = 320,
  parameter int IMG_H    = 240
) (
  input  logic                           clk_65mhz,
  input  logic                           sys_rst,
  input  logic                           wr_en,
  input  logic [$clog2(IMG_W*IMG_H)-1:0] wr_addr,
  input  pixel_t                         wr_data,
  input  chan_sel_t                      chan_sel,
  input  chan_t                          lower,
  input  chan_t                          upper,
  input  view_t                          view,
  output chan_t                          vga_r,
  output chan_t                          vga_g,
  output chan_t                          vga_b,
  output logic                           vga_hs,
  output logic                           vga_vs,
  output hcoord_t                        com_x,
  output vcoord_t                        com_y,
  output logic                           com_valid
);

  // scan position, cycle 0
  hcoord_t      hcount;
  vcoord_t      vcount;
  logic         hsync;
  logic         vsync;
  logic         blank;
  // frame store out, cycle 3
  pixel_t       pixel_fs;
  logic         in_image_fs;
  // luma stage out, cycle 5
  chan_t        luma;
  pixel_t       pixel_lc;
  logic         in_image_lc;
  coord_t       coord_d;
  // output cycle 6
  sync_bundle_t sync_d;
  coord_t       coord_tv;
  logic         mask;

  vga_timing #(
    .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
  ) timing (
    .clk_65mhz(clk_65mhz), .sys_rst(sys_rst), .hcount(hcount), .vcount(vcount),
    .hsync(hsync), .vsync(vsync), .blank(blank)
  );

  frame_store #(.IMG_W(IMG_W), .IMG_H(IMG_H)) store (
    .clk_65mhz(clk_65mhz), .sys_rst(sys_rst), .wr_en(wr_en), .wr_addr(wr_addr),
    .wr_data(wr_data), .hcount(hcount), .vcount(vcount), .pixel(pixel_fs),
    .in_image(in_image_fs)
  );

  luma_convert luma_conv (
    .clk_65mhz(clk_65mhz), .sys_rst(sys_rst), .pixel_in(pixel_fs),
    .in_image_in(in_image_fs), .luma(luma), .pixel_out(pixel_lc),
    .in_image_out(in_image_lc)
  );

  // coordinates meet the pixel at threshold input
  timing_delay #(.DEPTH(PIXEL_LATENCY - 1), .payload_t(coord_t)) coord_delay (
    .clk_65mhz(clk_65mhz), .sys_rst(sys_rst), .din({hcount, vcount}), .dout(coord_d)
  );

  // syncs and blank line up with the registered colors
  timing_delay #(.DEPTH(PIXEL_LATENCY), .payload_t(sync_bundle_t)) sync_delay (
    .clk_65mhz(clk_65mhz), .sys_rst(sys_rst), .din({hsync, vsync, blank}), .dout(sync_d)
  );

  threshold_view view_out (
    .clk_65mhz(clk_65mhz), .sys_rst(sys_rst), .pixel(pixel_lc), .luma(luma),
    .in_image(in_image_lc), .coord_in(coord_d), .blank(sync_d.blank),
    .chan_sel(chan_sel), .lower(lower), .upper(upper), .view(view),
    .com_x(com_x), .com_y(com_y), .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b),
    .mask(mask), .coord_out(coord_tv)
  );

  centroid com (
    .clk_65mhz(clk_65mhz), .sys_rst(sys_rst), .mask(mask), .coord(coord_tv),
    .com_x(com_x), .com_y(com_y), .com_valid(com_valid)
  );

  // active low at the connector
  assign vga_hs = ~sync_d.hsync;
  assign vga_vs = ~sync_d.vsync;

endmodule

//--- verif/video_sva.sv
module video_sva import vision_pkg::*; (
  input logic  clk_65mhz,
  input logic  sys_rst,
  input logic  blank,
  input chan_t vga_r,
  input chan_t vga_g,
  input chan_t vga_b,
  input logic  mask,
  input logic  com_valid
);

  // result strobe is a single-cycle pulse
  com_valid_pulse: assert property (@(posedge clk_65mhz) disable iff (sys_rst)
    com_valid |=> !com_valid)
    else $error("com_valid held high for two cycles");

  // blank from the counters reaches the pins PIXEL_LATENCY cycles later
  blank_black: assert property (@(posedge clk_65mhz) disable iff (sys_rst)
    $past(blank, PIXEL_LATENCY) |-> (vga_r == '0 && vga_g == '0 && vga_b == '0))
    else $error("color output nonzero during blank");

  // mask only inside the image, never in blanking
  mask_active: assert property (@(posedge clk_65mhz) disable iff (sys_rst)
    mask |-> !$past(blank, PIXEL_LATENCY))
    else $error("mask set during blank");

endmodule

bind video_top video_sva sva_view (
  .clk_65mhz(clk_65mhz), .sys_rst(sys_rst), .blank(blank), .vga_r(vga_r),
  .vga_g(vga_g), .vga_b(vga_b), .mask(mask), .com_valid(1'b0)
);

bind centroid video_sva sva_com (
  .clk_65mhz(clk_65mhz), .sys_rst(sys_rst), .blank(1'b0), .vga_r(4'h0),
  .vga_g(4'h0), .vga_b(4'h0), .mask(1'b0), .com_valid(com_valid)
);

//--- verif/tb_video.sv
module tb_video;
  import vision_pkg::*;

  // reduced screen, 32 x 20 total
  localparam int H_ACTIVE = 24;
  localparam int H_FRONT  = 2;
  localparam int H_SYNC   = 4;
  localparam int H_BACK   = 2;
  localparam int V_ACTIVE = 16;
  localparam int V_FRONT  = 1;
  localparam int V_SYNC   = 2;
  localparam int V_BACK   = 1;
  localparam int IMG_W    = 16;
  localparam int IMG_H    = 12;
  localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  localparam int FRAME    = H_TOTAL * V_TOTAL;
  localparam int ADDR_W       = $clog2(IMG_W * IMG_H);
  localparam int RESET_CYCLES = 8;

  // golden columns
  localparam int FIELDS    = 12;
  localparam int MAX_CASES = 16;
  localparam int F_BG      = 0;
  localparam int F_C0      = 1;
  localparam int F_R0      = 2;
  localparam int F_C1      = 3;
  localparam int F_R1      = 4;
  localparam int F_RECT    = 5;
  localparam int F_CHAN    = 6;
  localparam int F_LOW     = 7;
  localparam int F_UP      = 8;
  localparam int F_VIEW    = 9;
  localparam int F_COMX    = 10;
  localparam int F_COMY    = 11;

  logic              clk_65mhz;
  logic              sys_rst;
  logic              wr_en;
  logic [ADDR_W-1:0] wr_addr;
  pixel_t            wr_data;
  chan_sel_t         chan_sel;
  chan_t             lower;
  chan_t             upper;
  view_t             view;
  chan_t             vga_r;
  chan_t             vga_g;
  chan_t             vga_b;
  logic              vga_hs;
  logic              vga_vs;
  hcoord_t           com_x;
  vcoord_t           com_y;
  logic              com_valid;

  logic [15:0] golden [FIELDS*MAX_CASES];
  // scan position history, entry 6 is the pixel now at the pins
  hcoord_t     hist_h [7];
  vcoord_t     hist_v [7];
  int          n_cases;
  int          limit_cycles = 0;
  int          cur_x;
  int          cur_y;

  video_top #(
    .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
    .IMG_W(IMG_W), .IMG_H(IMG_H)
  ) dut (
    .clk_65mhz(clk_65mhz), .sys_rst(sys_rst), .wr_en(wr_en), .wr_addr(wr_addr),
    .wr_data(wr_data), .chan_sel(chan_sel), .lower(lower), .upper(upper),
    .view(view), .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b), .vga_hs(vga_hs),
    .vga_vs(vga_vs), .com_x(com_x), .com_y(com_y), .com_valid(com_valid)
  );

  initial begin
    clk_65mhz = 1'b0;
    forever #4 clk_65mhz = ~clk_65mhz;
  end

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_color(input string name, input chan_t got, input chan_t exp);
    if (got !== exp) begin
      report_failure($sformatf("** Error: %s = %h, expected %h at x %0d y %0d",
                               name, got, exp, cur_x, cur_y));
    end
  endtask

  task automatic check_sync(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("** Error: %s = %h, expected %h at x %0d y %0d",
                               name, got, exp, cur_x, cur_y));
    end
  endtask

  task automatic check_com(input hcoord_t got_x, input vcoord_t got_y,
                           input hcoord_t exp_x, input vcoord_t exp_y);
    if (got_x !== exp_x) begin
      report_failure($sformatf("** Error: com_x = %h, expected %h", got_x, exp_x));
    end
    if (got_y !== exp_y) begin
      report_failure($sformatf("** Error: com_y = %h, expected %h", got_y, exp_y));
    end
  endtask

  // one falling edge, then advance the scan model past the rising edge before it
  // reset parks it on (0,0), otherwise column then row wrap at the totals
  task automatic step();
    @(negedge clk_65mhz);
    for (int i = 6; i > 0; i--) begin
      hist_h[i] = hist_h[i-1];
      hist_v[i] = hist_v[i-1];
    end
    if (sys_rst) begin
      hist_h[0] = '0;
      hist_v[0] = '0;
    end else if (int'(hist_h[1]) == H_TOTAL - 1) begin
      hist_h[0] = '0;
      hist_v[0] = (int'(hist_v[1]) == V_TOTAL - 1) ? '0 : hist_v[1] + 1'b1;
    end else begin
      hist_h[0] = hist_h[1] + 1'b1;
      hist_v[0] = hist_v[1];
    end
  endtask

  // stops with the pins on screen position (0,0)
  task automatic wait_frame_start();
    do begin
      step();
    end while (!(hist_h[6] == '0 && hist_v[6] == '0));
  endtask

  function automatic int field(input int idx, input int f);
    return int'(golden[idx*FIELDS+f]);
  endfunction

  // background with one filled rectangle, corners inclusive
  function automatic pixel_t image_pixel(input int idx, input int col, input int row);
    logic in_rect;
    in_rect = (col >= field(idx, F_C0)) && (col <= field(idx, F_C1)) &&
              (row >= field(idx, F_R0)) && (row <= field(idx, F_R1));
    return pixel_t'(in_rect ? field(idx, F_RECT) : field(idx, F_BG));
  endfunction

  // 8-bit widening by top-bit replication, weighted sum >> 8, top nibble
  function automatic chan_t luma_of(input pixel_t p);
    int r8;
    int g8;
    int b8;
    int sum;
    r8  = int'({p.r, p.r[4:2]});
    g8  = int'({p.g, p.g[5:4]});
    b8  = int'({p.b, p.b[4:2]});
    sum = r8 * int'(LUMA_R_COEF) + g8 * int'(LUMA_G_COEF) + b8 * int'(LUMA_B_COEF);
    return chan_t'((sum >> 12) & 15);
  endfunction

  function automatic rgb444_t expected_color(input int idx, input int x, input int y);
    logic    in_img;
    logic    in_band;
    pixel_t  p;
    rgb444_t raw;
    chan_t   chan;
    if (x >= H_ACTIVE || y >= V_ACTIVE) begin
      return '0;
    end
    in_img = (x < IMG_W) && (y < IMG_H);
    // mirrored column
    p   = in_img ? image_pixel(idx, IMG_W - 1 - x, y) : '0;
    raw = '{r: p.r[4:1], g: p.g[5:2], b: p.b[4:1]};
    case (field(idx, F_CHAN))
      0:       chan = raw.r;
      1:       chan = raw.g;
      2:       chan = raw.b;
      default: chan = luma_of(p);
    endcase
    in_band = in_img && (int'(chan) >= field(idx, F_LOW)) &&
              (int'(chan) <= field(idx, F_UP));
    case (field(idx, F_VIEW))
      0:       return raw;
      1:       return '{r: chan, g: chan, b: chan};
      2:       return in_band ? '{r: 4'hF, g: 4'hF, b: 4'hF} : '0;
      default: begin
        if (x == field(idx, F_COMX) || y == field(idx, F_COMY)) begin
          return CROSS_COLOR;
        end
        return raw;
      end
    endcase
  endfunction

  task automatic run_case(input int idx);
    logic    seen;
    hcoord_t got_x;
    vcoord_t got_y;
    rgb444_t exp_c;
    logic    exp_hs;
    logic    exp_vs;
    chan_sel = chan_sel_t'(2'(field(idx, F_CHAN)));
    lower    = chan_t'(field(idx, F_LOW));
    upper    = chan_t'(field(idx, F_UP));
    view     = view_t'(2'(field(idx, F_VIEW)));
    // whole image through the write port, one pixel per cycle
    for (int row = 0; row < IMG_H; row++) begin
      for (int col = 0; col < IMG_W; col++) begin
        wr_en   = 1'b1;
        wr_addr = ADDR_W'(row * IMG_W + col);
        wr_data = image_pixel(idx, col, row);
        step();
      end
    end
    wr_en = 1'b0;
    // let the last write clear the read pipe
    repeat (8) step();
    wait_frame_start();
    // first clean frame feeds the sums
    repeat (FRAME) step();
    seen  = 1'b0;
    got_x = '0;
    got_y = '0;
    for (int i = 0; i < FRAME; i++) begin
      if (com_valid && !seen) begin
        seen  = 1'b1;
        got_x = com_x;
        got_y = com_y;
      end
      step();
    end
    if (!seen) begin
      report_failure($sformatf("no centroid result came out for case %0d", idx));
    end
    check_com(got_x, got_y, hcoord_t'(field(idx, F_COMX)), vcoord_t'(field(idx, F_COMY)));
    // third frame, every position including blanking
    for (int i = 0; i < FRAME; i++) begin
      cur_x  = int'(hist_h[6]);
      cur_y  = int'(hist_v[6]);
      exp_c  = expected_color(idx, cur_x, cur_y);
      exp_hs = !((cur_x >= H_ACTIVE + H_FRONT) && (cur_x < H_ACTIVE + H_FRONT + H_SYNC));
      exp_vs = !((cur_y >= V_ACTIVE + V_FRONT) && (cur_y < V_ACTIVE + V_FRONT + V_SYNC));
      check_color("vga_r", vga_r, exp_c.r);
      check_color("vga_g", vga_g, exp_c.g);
      check_color("vga_b", vga_b, exp_c.b);
      check_sync("vga_hs", vga_hs, exp_hs);
      check_sync("vga_vs", vga_vs, exp_vs);
      step();
    end
  endtask

  initial begin
    sys_rst  = 1'b1;
    wr_en    = 1'b0;
    wr_addr  = '0;
    wr_data  = '0;
    chan_sel = CHAN_RED;
    lower    = '0;
    upper    = '0;
    view     = VIEW_RAW;
    for (int i = 0; i < 7; i++) begin
      hist_h[i] = '0;
      hist_v[i] = '0;
    end
    // unused slots keep a marker no channel field can hold
    for (int i = 0; i < FIELDS * MAX_CASES; i++) begin
      golden[i] = 16'hdead;
    end
    $readmemh("verif/video_golden.txt", golden);
    n_cases = 0;
    while (n_cases < MAX_CASES && golden[n_cases*FIELDS+F_CHAN] != 16'hdead) begin
      n_cases++;
    end
    if (n_cases == 0) begin
      report_failure("the golden file holds no test cases");
    end
    limit_cycles = n_cases * (4 * FRAME + IMG_W * IMG_H) + 2 * FRAME + RESET_CYCLES;
    repeat (RESET_CYCLES) step();
    sys_rst = 1'b0;
    for (int c = 0; c < n_cases; c++) begin
      run_case(c);
    end
    $display("*** PASSED ***");
    $finish;
  end

  // watchdog, armed once the case count is known
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk_65mhz);
    $display("timeout: the run did not finish within %0d cycles", limit_cycles);
    $display("*** FAILED ***");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- verif/video_golden.txt
// one case per line, all hex
// bg col0 row0 col1 row1 rect_color chan lower upper view com_x com_y
// rectangle corners are image columns and rows, inclusive
// chan 0 red 1 green 2 blue 3 luma, view 0 raw 1 gray 2 mask 3 cross
// com_x and com_y are screen coordinates, image is mirrored left to right
// red block, red threshold
0000 0002 0001 0005 0004 F800 0000 0008 000F 0000 000B 0002
// green block on blue, luma band
001F 0008 0003 000B 000A 07E0 0003 0006 0009 0001 0005 0006
// white block, green band misses everything
0000 0000 0000 0003 0003 FFFF 0001 0005 0007 0002 0000 0000
// green corner block, crosshair view
0000 000C 0008 000F 000B 07E0 0001 000F 000F 0003 0001 0009
// whole image inside the luma band
FFFF 0004 0002 0006 0003 001F 0003 0001 000D 0002 0007 0005
// single blue pixel on red
F800 0000 000B 0000 000B 001F 0002 0008 000F 0003 000F 000B
// background selected, block excluded
07E0 0003 0005 000E 0009 FFFF 0000 0000 0003 0001 0007 0004
// mid gray stripe, crosshair view
0000 0001 0000 0002 000B 7BEF 0000 0007 0007 0003 000D 0005

//--- files.f
common/vision_pkg.sv
logic/vga_timing.sv
logic/timing_delay.sv
frame_store/frame_store.sv
logic/luma_convert.sv
logic/threshold_view.sv
logic/centroid.sv
logic/video_top.sv
verif/video_sva.sv
verif/tb_video.sv

//--- Makefile
SIM := obj_dir/tb_video_sim

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f files.f \
		--top-module tb_video -Mdir obj_dir -o tb_video_sim

run: build
	./$(SIM) | tee /dev/stderr | grep -q '^\*\*\* PASSED \*\*\*$$'

lint:
	verilator --lint-only --timing -f files.f --top-module tb_video

clean:
	rm -rf obj_dir
